//--- verilog/apb_sys_pkg.sv
`default_nettype none

package apb_sys_pkg;

   // Bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Peripheral select field and address map
   localparam int SEL_HI = 15;
   localparam int SEL_LO = 12;
   localparam logic [SEL_HI-SEL_LO:0] SEL_REGFILE = 4'd0;
   localparam logic [SEL_HI-SEL_LO:0] SEL_TIMER   = 4'd1;

   localparam int RF_WORDS  = 8;
   localparam int RF_IDX_W  = $clog2(RF_WORDS);
   localparam int RF_IDX_LO = 2;  // Word aligned

   // Timer word offsets, address bits [3:2]
   localparam int TMR_OFF_HI = 3;
   localparam int TMR_OFF_LO = 2;
   localparam logic [TMR_OFF_HI-TMR_OFF_LO:0] TMR_CTRL   = 2'd0;
   localparam logic [TMR_OFF_HI-TMR_OFF_LO:0] TMR_COUNT  = 2'd1;
   localparam logic [TMR_OFF_HI-TMR_OFF_LO:0] TMR_CMP    = 2'd2;
   localparam logic [TMR_OFF_HI-TMR_OFF_LO:0] TMR_STATUS = 2'd3;

   // Timer control word fields
   localparam int CTRL_EN_BIT    = 0;
   localparam int CTRL_IRQEN_BIT = 1;
   localparam int PRESC_HI       = 15;
   localparam int PRESC_LO       = 8;

   // Bridge states
   localparam logic ST_IDLE   = 1'b0;
   localparam logic ST_ACCESS = 1'b1;

   // Replace the bytes of old_w whose strobe bit is set
   function automatic logic [DATA_W-1:0] strb_merge(input logic [DATA_W-1:0] old_w,
                                                    input logic [DATA_W-1:0] new_w,
                                                    input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

endpackage

`default_nettype wire

//--- verilog/iob2apb.sv
`timescale 1ns/1ns
`default_nettype none

module iob2apb
   import apb_sys_pkg::*;
(
   input  logic              clk_i,
   input  logic              cke_i,
   input  logic              arst_n_i,

   // IOb slave side
   input  logic              iob_avalid_i,
   input  logic [ADDR_W-1:0] iob_addr_i,
   input  logic [DATA_W-1:0] iob_wdata_i,
   input  logic [STRB_W-1:0] iob_wstrb_i,
   output logic              iob_ready_o,
   output logic              iob_rvalid_o,
   output logic [DATA_W-1:0] iob_rdata_o,

   // APB master side
   output logic              apb_sel_o,
   output logic              apb_enable_o,
   output logic [ADDR_W-1:0] apb_addr_o,
   output logic              apb_write_o,
   output logic [STRB_W-1:0] apb_wstrb_o,
   output logic [DATA_W-1:0] apb_wdata_o,
   input  logic              apb_ready_i,
   input  logic [DATA_W-1:0] apb_rdata_i
);

   logic state_q;
   logic accept;
   logic done;

   // New request taken while idle
   assign accept = (state_q == ST_IDLE) && iob_avalid_i && iob_ready_o;

   // Ready only counts once the access phase is open
   assign done = (state_q == ST_ACCESS) && apb_enable_o && apb_ready_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q      <= ST_IDLE;
         apb_sel_o    <= 1'b0;
         apb_enable_o <= 1'b0;
         iob_ready_o  <= 1'b1;   // Idle bridge accepts at once
         iob_rvalid_o <= 1'b0;
      end else if (cke_i) begin
         iob_rvalid_o <= 1'b0;   // Pulse lasts one enabled cycle

         case (state_q)
            ST_IDLE: begin
               if (accept) begin
                  state_q     <= ST_ACCESS;
                  apb_sel_o   <= 1'b1;  // Setup phase
                  iob_ready_o <= 1'b0;
               end
            end

            default: begin
               if (!apb_enable_o) begin
                  apb_enable_o <= 1'b1;  // Setup over, enter access
               end else if (done) begin
                  // Close transfer and answer the master
                  state_q      <= ST_IDLE;
                  apb_sel_o    <= 1'b0;
                  apb_enable_o <= 1'b0;
                  iob_rvalid_o <= 1'b1;
                  iob_ready_o  <= 1'b1;
               end
            end
         endcase
      end
   end

   // Request payload, held for the whole transfer
   always_ff @(posedge clk_i) begin
      if (cke_i && accept) begin
         apb_addr_o  <= iob_addr_i;
         apb_write_o <= (iob_wstrb_i != '0);  // Any strobe bit means write
         apb_wstrb_o <= iob_wstrb_i;
         apb_wdata_o <= iob_wdata_i;
      end
   end

   // Response data
   always_ff @(posedge clk_i) begin
      if (cke_i && done) begin
         iob_rdata_o <= apb_rdata_i;
      end
   end

endmodule

`default_nettype wire

//--- verilog/apb_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module apb_decoder
   import apb_sys_pkg::*;
(
   // From and to the bridge
   input  logic              apb_sel_i,
   input  logic [ADDR_W-1:0] apb_addr_i,
   output logic              apb_ready_o,
   output logic [DATA_W-1:0] apb_rdata_o,

   // Register file
   output logic              rf_sel_o,
   input  logic              rf_ready_i,
   input  logic [DATA_W-1:0] rf_rdata_i,

   // Timer
   output logic              tmr_sel_o,
   input  logic              tmr_ready_i,
   input  logic [DATA_W-1:0] tmr_rdata_i
);

   logic [SEL_HI-SEL_LO:0] region;

   assign region = apb_addr_i[SEL_HI:SEL_LO];

   assign rf_sel_o  = apb_sel_i && (region == SEL_REGFILE);
   assign tmr_sel_o = apb_sel_i && (region == SEL_TIMER);

   // Response steering
   always_comb begin
      case (region)
         SEL_REGFILE: begin
            apb_ready_o = rf_ready_i;
            apb_rdata_o = rf_rdata_i;
         end
         SEL_TIMER: begin
            apb_ready_o = tmr_ready_i;
            apb_rdata_o = tmr_rdata_i;
         end
         default: begin
            // Nobody home, finish right away with zero
            apb_ready_o = 1'b1;
            apb_rdata_o = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/apb_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module apb_regfile
   import apb_sys_pkg::*;
(
   input  logic              clk_i,
   input  logic              cke_i,
   input  logic              arst_n_i,

   input  logic              sel_i,
   input  logic              enable_i,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic              write_i,
   input  logic [STRB_W-1:0] wstrb_i,
   input  logic [DATA_W-1:0] wdata_i,
   output logic              ready_o,
   output logic [DATA_W-1:0] rdata_o
);

   logic [DATA_W-1:0]   mem [RF_WORDS];
   logic [RF_IDX_W-1:0] idx;
   logic                access;
   logic                rd_first;
   logic                wait_q;
   logic [DATA_W-1:0]   rdata_q;

   assign idx    = addr_i[RF_IDX_LO +: RF_IDX_W];
   assign access = sel_i && enable_i;

   // First access cycle of a read, data gets fetched here
   assign rd_first = access && !write_i && !wait_q;

   // Writes finish at once, reads one cycle later
   assign ready_o = access && (write_i || wait_q);
   assign rdata_o = rdata_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wait_q <= 1'b0;
      end else if (cke_i) begin
         wait_q <= rd_first;
      end
   end

   // Register storage
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < RF_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (cke_i && access && write_i) begin
         mem[idx] <= strb_merge(mem[idx], wdata_i, wstrb_i);  // Byte lanes
      end
   end

   always_ff @(posedge clk_i) begin
      if (cke_i && rd_first) begin
         rdata_q <= mem[idx];
      end
   end

endmodule

`default_nettype wire

//--- verilog/apb_timer.sv
`timescale 1ns/1ns
`default_nettype none

module apb_timer
   import apb_sys_pkg::*;
(
   input  logic              clk_i,
   input  logic              cke_i,
   input  logic              arst_n_i,

   input  logic              sel_i,
   input  logic              enable_i,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic              write_i,
   input  logic [STRB_W-1:0] wstrb_i,
   input  logic [DATA_W-1:0] wdata_i,
   output logic              ready_o,
   output logic [DATA_W-1:0] rdata_o,
   output logic              irq_o
);

   logic [DATA_W-1:0]            ctrl_q;
   logic [DATA_W-1:0]            count_q;
   logic [DATA_W-1:0]            cmp_q;
   logic                         status_q;
   logic [PRESC_HI-PRESC_LO:0]   presc_cnt_q;
   logic [TMR_OFF_HI-TMR_OFF_LO:0] off;
   logic                         wr;
   logic                         tick;
   logic                         match;
   logic                         clr;

   assign off = addr_i[TMR_OFF_HI:TMR_OFF_LO];
   assign wr  = sel_i && enable_i && write_i;

   // Count step every prescale+1 cycles
   assign tick  = ctrl_q[CTRL_EN_BIT] && (presc_cnt_q == ctrl_q[PRESC_HI:PRESC_LO]);
   assign match = ctrl_q[CTRL_EN_BIT] && (count_q == cmp_q);
   assign clr   = wr && (off == TMR_STATUS) && wstrb_i[0] && wdata_i[0];  // W1C

   assign ready_o = 1'b1;  // No wait states

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctrl_q      <= '0;
         count_q     <= '0;
         cmp_q       <= '0;
         status_q    <= 1'b0;
         presc_cnt_q <= '0;
         irq_o       <= 1'b0;
      end else if (cke_i) begin
         if (wr && off == TMR_CTRL) ctrl_q <= strb_merge(ctrl_q, wdata_i, wstrb_i);
         if (wr && off == TMR_CMP) cmp_q <= strb_merge(cmp_q, wdata_i, wstrb_i);

         // Prescaler restarts on each tick or while stopped
         if (!ctrl_q[CTRL_EN_BIT] || tick) begin
            presc_cnt_q <= '0;
         end else begin
            presc_cnt_q <= presc_cnt_q + 1'b1;
         end

         // A load wins over counting
         if (wr && off == TMR_COUNT) begin
            count_q <= strb_merge(count_q, wdata_i, wstrb_i);
         end else if (tick) begin
            count_q <= count_q + 1'b1;
         end

         if (match) begin
            status_q <= 1'b1;  // Sticky, a new match beats a clear
         end else if (clr) begin
            status_q <= 1'b0;
         end

         irq_o <= status_q && ctrl_q[CTRL_IRQEN_BIT];
      end
   end

   always_comb begin
      case (off)
         TMR_CTRL:  rdata_o = ctrl_q;
         TMR_COUNT: rdata_o = count_q;
         TMR_CMP:   rdata_o = cmp_q;
         default:   rdata_o = {{(DATA_W-1){1'b0}}, status_q};
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/apb_sys_top.sv
`timescale 1ns/1ns
`default_nettype none

module apb_sys_top
   import apb_sys_pkg::*;
(
   input  logic              clk_i,
   input  logic              cke_i,
   input  logic              arst_n_i,

   input  logic              iob_avalid_i,
   input  logic [ADDR_W-1:0] iob_addr_i,
   input  logic [DATA_W-1:0] iob_wdata_i,
   input  logic [STRB_W-1:0] iob_wstrb_i,
   output logic              iob_ready_o,
   output logic              iob_rvalid_o,
   output logic [DATA_W-1:0] iob_rdata_o,

   output logic              irq_o
);

   // Shared APB bus
   logic              apb_sel;
   logic              apb_enable;
   logic [ADDR_W-1:0] apb_addr;
   logic              apb_write;
   logic [STRB_W-1:0] apb_wstrb;
   logic [DATA_W-1:0] apb_wdata;
   logic              apb_ready;
   logic [DATA_W-1:0] apb_rdata;

   // Per peripheral select and response
   logic              rf_sel;
   logic              rf_ready;
   logic [DATA_W-1:0] rf_rdata;
   logic              tmr_sel;
   logic              tmr_ready;
   logic [DATA_W-1:0] tmr_rdata;

   iob2apb iob2apb_i (
      .clk_i       (clk_i),
      .cke_i       (cke_i),
      .arst_n_i    (arst_n_i),
      .iob_avalid_i(iob_avalid_i),
      .iob_addr_i  (iob_addr_i),
      .iob_wdata_i (iob_wdata_i),
      .iob_wstrb_i (iob_wstrb_i),
      .iob_ready_o (iob_ready_o),
      .iob_rvalid_o(iob_rvalid_o),
      .iob_rdata_o (iob_rdata_o),
      .apb_sel_o   (apb_sel),
      .apb_enable_o(apb_enable),
      .apb_addr_o  (apb_addr),
      .apb_write_o (apb_write),
      .apb_wstrb_o (apb_wstrb),
      .apb_wdata_o (apb_wdata),
      .apb_ready_i (apb_ready),
      .apb_rdata_i (apb_rdata)
   );

   apb_decoder apb_decoder_i (
      .apb_sel_i  (apb_sel),
      .apb_addr_i (apb_addr),
      .apb_ready_o(apb_ready),
      .apb_rdata_o(apb_rdata),
      .rf_sel_o   (rf_sel),
      .rf_ready_i (rf_ready),
      .rf_rdata_i (rf_rdata),
      .tmr_sel_o  (tmr_sel),
      .tmr_ready_i(tmr_ready),
      .tmr_rdata_i(tmr_rdata)
   );

   apb_regfile apb_regfile_i (
      .clk_i   (clk_i),
      .cke_i   (cke_i),
      .arst_n_i(arst_n_i),
      .sel_i   (rf_sel),
      .enable_i(apb_enable),
      .addr_i  (apb_addr),
      .write_i (apb_write),
      .wstrb_i (apb_wstrb),
      .wdata_i (apb_wdata),
      .ready_o (rf_ready),
      .rdata_o (rf_rdata)
   );

   apb_timer apb_timer_i (
      .clk_i   (clk_i),
      .cke_i   (cke_i),
      .arst_n_i(arst_n_i),
      .sel_i   (tmr_sel),
      .enable_i(apb_enable),
      .addr_i  (apb_addr),
      .write_i (apb_write),
      .wstrb_i (apb_wstrb),
      .wdata_i (apb_wdata),
      .ready_o (tmr_ready),
      .rdata_o (tmr_rdata),
      .irq_o   (irq_o)
   );

endmodule

`default_nettype wire

//--- tb/tb_iob_tasks.svh
`ifndef TB_IOB_TASKS_SVH
`define TB_IOB_TASKS_SVH

// Wait for rvalid after acceptance, the request cycle counts as the first
task automatic wait_response(output logic [DATA_W-1:0] rdata, output int lat);
   lat = 1;
   while (!iob_rvalid_o) begin
      @(posedge clk_i);
      #1;
      lat++;
   end
   rdata = iob_rdata_o;
endtask

// One IOb request, called and returning 1 ns after a rising edge
task automatic issue_request(input  logic [ADDR_W-1:0] addr,
                             input  logic [DATA_W-1:0] wdata,
                             input  logic [STRB_W-1:0] wstrb,
                             output logic [DATA_W-1:0] rdata,
                             output int                lat);
   while (!iob_ready_o) begin
      @(posedge clk_i);
      #1;
   end
   iob_avalid_i = 1'b1;
   iob_addr_i   = addr;
   iob_wdata_i  = wdata;
   iob_wstrb_i  = wstrb;
   @(posedge clk_i);  // Accepted on this edge
   #1;
   iob_avalid_i = 1'b0;
   iob_wstrb_i  = '0;
   wait_response(rdata, lat);
endtask

task automatic iob_write(input  logic [ADDR_W-1:0] addr,
                         input  logic [DATA_W-1:0] wdata,
                         input  logic [STRB_W-1:0] wstrb,
                         output int                lat);
   logic [DATA_W-1:0] ignored;
   issue_request(addr, wdata, wstrb, ignored, lat);
endtask

task automatic iob_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata,
                        output int lat);
   issue_request(addr, '0, '0, rdata, lat);  // Zero strobe means read
endtask

`endif

//--- tb/tb_apb_sys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_apb_sys
   import apb_sys_pkg::*;
();

   localparam int MAX_CYCLES = 2000;  // Full sequence runs near 550 cycles

   localparam logic [ADDR_W-1:0] TMR_CTRL_A   = 16'h1000;
   localparam logic [ADDR_W-1:0] TMR_COUNT_A  = 16'h1004;
   localparam logic [ADDR_W-1:0] TMR_CMP_A    = 16'h1008;
   localparam logic [ADDR_W-1:0] TMR_STATUS_A = 16'h100C;
   localparam logic [ADDR_W-1:0] NOMAP_A      = 16'h2004;  // Low bits alias rf word 1
   localparam logic [ADDR_W-1:0] NOMAP_B      = 16'hF008;

   logic              clk_i = 1'b0;
   logic              cke_i;
   logic              arst_n_i;
   logic              iob_avalid_i;
   logic [ADDR_W-1:0] iob_addr_i;
   logic [DATA_W-1:0] iob_wdata_i;
   logic [STRB_W-1:0] iob_wstrb_i;
   logic              iob_ready_o;
   logic              iob_rvalid_o;
   logic [DATA_W-1:0] iob_rdata_o;
   logic              irq_o;

   int err_cnt   = 0;
   int check_cnt = 0;
   int cyc_cnt   = 0;
   int seed      = 63;

   // Request tracker
   logic outstanding_q;
   int   lat_q;
   int   exp_lat_q;
   int   acc_cnt;
   int   rsp_cnt;

   logic [DATA_W-1:0] rf_model [8];

   always #2 clk_i = ~clk_i;

   always @(posedge clk_i) cyc_cnt <= cyc_cnt + 1;

   apb_sys_top apb_sys_top_i (.*);

   `include "tb_iob_tasks.svh"

   // Writes and timer accesses take 3 cycles, regfile reads one more
   function automatic int expected_latency(input logic [ADDR_W-1:0] addr,
                                           input logic [STRB_W-1:0] wstrb);
      if (wstrb != '0) return 3;
      if (addr[15:12] == 4'h0) return 4;
      return 3;
   endfunction

   task automatic check_value(input string name, input logic [DATA_W-1:0] exp_v,
                              input logic [DATA_W-1:0] act_v);
      check_cnt++;
      assert (act_v === exp_v) else begin
         err_cnt++;
         $display("error %s: expected %h, actual %h", name, exp_v, act_v);
      end
   endtask

   task automatic check_bit(input string name, input logic exp_b, input logic act_b);
      check_value(name, {{(DATA_W-1){1'b0}}, exp_b}, {{(DATA_W-1){1'b0}}, act_b});
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk_i);
      #1;
   endtask

   task automatic compare_regfile(input string name);
      logic [DATA_W-1:0] rd;
      int                lat;
      for (int i = 0; i < 8; i++) begin
         iob_read(16'(4 * i), rd, lat);
         check_value(name, rf_model[i], rd);
         check_value("rf read latency", 4, lat);
      end
   endtask

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         outstanding_q <= 1'b0;
         lat_q         <= 0;
         exp_lat_q     <= 0;
         acc_cnt       <= 0;
         rsp_cnt       <= 0;
      end else if (cke_i) begin
         if (iob_rvalid_o) begin
            outstanding_q <= 1'b0;
            rsp_cnt       <= rsp_cnt + 1;
         end else if (outstanding_q) begin
            lat_q <= lat_q + 1;
         end
         if (iob_avalid_i && iob_ready_o) begin  // Acceptance
            outstanding_q <= 1'b1;
            lat_q         <= 1;  // Request cycle counts as the first
            exp_lat_q     <= expected_latency(iob_addr_i, iob_wstrb_i);
            acc_cnt       <= acc_cnt + 1;
         end
      end
   end

   // Checked mid cycle, where every signal is settled
   assert property (@(negedge clk_i) disable iff (!arst_n_i)
                    outstanding_q && !iob_rvalid_o |-> !iob_ready_o)
   else begin
      err_cnt++;
      $display("Ready went high before the open request answered at %0t", $time);
   end

   assert property (@(negedge clk_i) disable iff (!arst_n_i) iob_rvalid_o |-> outstanding_q)
   else begin
      err_cnt++;
      $display("Rvalid appeared without an accepted request at %0t", $time);
   end

   assert property (@(negedge clk_i) disable iff (!arst_n_i)
                    iob_rvalid_o |-> lat_q == exp_lat_q)
   else begin
      err_cnt++;
      $display("Response latency %0d differs from %0d at %0t", lat_q, exp_lat_q, $time);
   end

   initial begin
      logic [DATA_W-1:0] rd;
      logic [DATA_W-1:0] rd2;
      logic [DATA_W-1:0] mask;
      logic [STRB_W-1:0] strb;
      int                lat;

      cke_i        = 1'b1;
      arst_n_i     = 1'b0;
      iob_avalid_i = 1'b0;
      iob_addr_i   = '0;
      iob_wdata_i  = '0;
      iob_wstrb_i  = '0;
      repeat (5) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;

      check_bit("reset ready", 1'b1, iob_ready_o);
      check_bit("reset rvalid", 1'b0, iob_rvalid_o);
      check_bit("reset irq", 1'b0, irq_o);
      for (int i = 0; i < 8; i++) rf_model[i] = '0;
      compare_regfile("reset regfile");
      for (int i = 0; i < 4; i++) begin
         iob_read(TMR_CTRL_A + 16'(4 * i), rd, lat);
         check_value("reset timer", 0, rd);
      end

      // Register file, full words then partial strobes
      for (int i = 0; i < 8; i++) begin
         rf_model[i] = $random(seed);
         iob_write(16'(4 * i), rf_model[i], 4'hF, lat);
         check_value("rf write latency", 3, lat);
      end
      compare_regfile("rf full write");
      for (int i = 0; i < 8; i++) begin
         rd   = $random(seed);
         strb = 4'(i + 1);
         mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
         rf_model[i] = (rf_model[i] & ~mask) | (rd & mask);
         iob_write(16'(4 * i), rd, strb, lat);
      end
      compare_regfile("rf strobe write");

      // Unmapped space
      iob_read(NOMAP_A, rd, lat);
      check_value("unmapped read", 0, rd);
      check_value("unmapped read latency", 3, lat);
      iob_read(NOMAP_B, rd, lat);
      check_value("unmapped read", 0, rd);
      iob_write(NOMAP_A, 32'hDEAD_BEEF, 4'hF, lat);
      check_value("unmapped write latency", 3, lat);
      iob_write(NOMAP_B, 32'h1234_5678, 4'hF, lat);
      compare_regfile("rf after unmapped write");
      iob_read(TMR_COUNT_A, rd, lat);
      check_value("count after unmapped write", 0, rd);
      check_value("timer read latency", 3, lat);
      iob_read(TMR_CMP_A, rd, lat);
      check_value("cmp after unmapped write", 0, rd);

      // Timer count
      iob_read(TMR_COUNT_A, rd, lat);
      iob_read(TMR_COUNT_A, rd2, lat);
      check_value("stopped count", rd, rd2);
      iob_write(TMR_COUNT_A, 32'h0000_1000, 4'hF, lat);
      iob_read(TMR_COUNT_A, rd, lat);
      check_value("count load", 32'h0000_1000, rd);
      iob_write(TMR_CTRL_A, 32'h0000_0001, 4'hF, lat);  // Enable, prescale 0
      idle_cycles(10);
      iob_read(TMR_COUNT_A, rd, lat);
      check_bit("count advances", 1'b1, rd > 32'h0000_1000);
      iob_write(TMR_CTRL_A, 32'h0, 4'hF, lat);
      iob_write(TMR_COUNT_A, 32'h0000_5000, 4'hF, lat);
      iob_read(TMR_COUNT_A, rd, lat);
      check_value("count reload", 32'h0000_5000, rd);

      // Compare match, first with the interrupt enabled
      iob_write(TMR_COUNT_A, 32'h0000_0100, 4'hF, lat);
      iob_write(TMR_CMP_A, 32'h0000_0114, 4'hF, lat);   // Count plus 20
      iob_write(TMR_CTRL_A, 32'h0000_0003, 4'hF, lat);
      idle_cycles(60);
      check_bit("irq on match", 1'b1, irq_o);
      iob_read(TMR_STATUS_A, rd, lat);
      check_value("status on match", 1, rd);
      iob_write(TMR_STATUS_A, 32'h1, 4'hF, lat);
      iob_read(TMR_STATUS_A, rd, lat);
      check_value("status cleared", 0, rd);
      check_bit("irq cleared", 1'b0, irq_o);
      iob_write(TMR_CTRL_A, 32'h0, 4'hF, lat);
      iob_write(TMR_COUNT_A, 32'h0000_0200, 4'hF, lat);
      iob_write(TMR_CMP_A, 32'h0000_0214, 4'hF, lat);
      iob_write(TMR_CTRL_A, 32'h0000_0001, 4'hF, lat);  // No interrupt enable
      idle_cycles(60);
      check_bit("irq masked", 1'b0, irq_o);
      iob_read(TMR_STATUS_A, rd, lat);
      check_value("status masked match", 1, rd);
      iob_write(TMR_STATUS_A, 32'h1, 4'hF, lat);
      iob_write(TMR_CTRL_A, 32'h0, 4'hF, lat);

      // Clock enable held low across a request
      iob_read(TMR_COUNT_A, rd, lat);
      idle_cycles(1);
      cke_i        = 1'b0;
      iob_avalid_i = 1'b1;
      iob_addr_i   = TMR_COUNT_A;
      iob_wstrb_i  = '0;
      for (int i = 0; i < 10; i++) begin
         idle_cycles(1);
         check_bit("rvalid with cke low", 1'b0, iob_rvalid_o);
      end
      cke_i = 1'b1;
      idle_cycles(1);
      iob_avalid_i = 1'b0;
      wait_response(rd2, lat);
      check_value("count across cke low", rd, rd2);
      check_value("latency after cke low", 3, lat);

      idle_cycles(2);
      check_value("responses per request", acc_cnt, rsp_cnt);
      $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      wait (cyc_cnt >= MAX_CYCLES);
      $display("Timeout after %0d cycles, a request never completed", MAX_CYCLES);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
+incdir+tb
verilog/apb_sys_pkg.sv
verilog/iob2apb.sv
verilog/apb_decoder.sv
verilog/apb_regfile.sv
verilog/apb_timer.sv
verilog/apb_sys_top.sv
tb/tb_apb_sys.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_apb_sys \
   -f project.f -o sim_apb_sys \
   && ./obj_dir/sim_apb_sys | tee sim.log
grep -qx "Test completed successfully" sim.log 2>/dev/null \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
